//--- aw_remap.f
+incdir+design
design/axi_aw_pkg.sv
design/remap_pkg.sv
design/remap_cfg_wb.sv
design/l1_tlb.sv
design/l2_tlb.sv
design/aw_sender.sv
design/aw_remap_top.sv
sim/clk_rst_gen.sv
sim/tb_aw_remap.sv

//--- run_sim.sh
#!/bin/sh
# compiles the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -f aw_remap.f --top-module tb_aw_remap -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_aw_remap)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "Simulation finished: PASS"; then
  exit 0
fi
echo "pass message not found"
exit 1

//--- sim/tb_aw_remap.sv
// directed testbench for aw_remap_top
// inputs change 1 ns after the rising edge, outputs are sampled on the falling edge
// the expected beats come from a table model kept next to the Wishbone writes

`timescale 1ns/1ps
`include "remap_config.svh"

module tb_aw_remap
  import axi_aw_pkg::*;
  import remap_pkg::*;
();

  localparam int    PB        = `REMAP_PAGE_BITS;
  localparam int    L1N       = `REMAP_L1_ENTRIES;
  localparam int    L2N       = `REMAP_L2_ENTRIES;
  localparam int    TIMEOUT   = 200;
  localparam addr_t OFFS_MASK = addr_t'((1 << PB) - 1);

  logic         axi4_aclk;
  logic         axi4_arstn;
  logic         cfg_cyc;
  logic         cfg_stb;
  logic         cfg_we;
  logic [8:0]   cfg_adr;
  logic [31:0]  cfg_dat_w;
  logic         cfg_ack;
  logic [31:0]  cfg_dat_r;
  logic         s_aw_valid;
  aw_chan_t     s_aw;
  logic         s_aw_ready;
  logic         m_aw_valid;
  aw_chan_t     m_aw;
  logic         m_aw_ready;
  miss_t        miss;
  logic         stall_en;
  logic [255:0] stall_pat;
  logic [7:0]   pat_idx;

  tlb_entry_t l1_model [L1N];
  tlb_entry_t l2_model [L2N];
  aw_chan_t   exp_q[$];
  miss_t      miss_exp_q[$];
  int         mismatches;
  int         protocol_errs;
  int         timeouts;
  int         beats_seen;
  int         misses_seen;

  clk_rst_gen clk_gen_i (
    .axi4_aclk_o  (axi4_aclk),
    .axi4_arstn_o (axi4_arstn)
  );

  aw_remap_top dut_i (
    .axi4_aclk    (axi4_aclk),
    .axi4_arstn   (axi4_arstn),
    .cfg_cyc_i    (cfg_cyc),
    .cfg_stb_i    (cfg_stb),
    .cfg_we_i     (cfg_we),
    .cfg_adr_i    (cfg_adr),
    .cfg_dat_i    (cfg_dat_w),
    .cfg_ack_o    (cfg_ack),
    .cfg_dat_o    (cfg_dat_r),
    .s_aw_valid_i (s_aw_valid),
    .s_aw_i       (s_aw),
    .s_aw_ready_o (s_aw_ready),
    .m_aw_valid_o (m_aw_valid),
    .m_aw_o       (m_aw),
    .m_aw_ready_i (m_aw_ready),
    .miss_o       (miss)
  );

  // about half the cycles stall the master side while back-pressure is enabled
  initial begin : ready_gen
    m_aw_ready = 1'b1;
    pat_idx    = '0;
    forever begin
      @(posedge axi4_aclk);
      #1;
      m_aw_ready = stall_en ? stall_pat[pat_idx] : 1'b1;
      pat_idx    = pat_idx + 8'd1;
    end
  end

  task automatic check_aw(input aw_chan_t got, input aw_chan_t exp);
    if (got !== exp) begin
      $display("FAILED at %0t: AW beat id %0h addr %h (beat %h), expected addr %h (beat %h)",
               $time, got.id, got.addr, got, exp.addr, exp);
      mismatches++;
    end
  endtask

  task automatic check_miss(input miss_t got, input miss_t exp);
    if (got !== exp) begin
      $display("FAILED at %0t: miss report id %0h addr %h, expected id %0h addr %h",
               $time, got.id, got.addr, exp.id, exp.addr);
      mismatches++;
    end
  endtask

  task automatic timeout_error(input string what);
    $display("timeout: no %s within %0d cycles at %0t", what, TIMEOUT, $time);
    timeouts++;
  endtask

  // master beats are matched by id and miss reports arrive in order
  always @(negedge axi4_aclk) begin : monitor
    int    k;
    miss_t mexp;
    if (axi4_arstn && m_aw_valid && m_aw_ready) begin
      k = -1;
      for (int i = 0; i < exp_q.size(); i++) begin
        if (k < 0 && exp_q[i].id == m_aw.id) k = i;
      end
      if (k < 0) begin
        $display("error: master beat id %0h at %0t was not expected", m_aw.id, $time);
        protocol_errs++;
      end else begin
        check_aw(m_aw, exp_q[k]);
        exp_q.delete(k);
      end
      beats_seen++;
    end
    if (axi4_arstn && miss.valid) begin
      if (miss_exp_q.size() == 0) begin
        $display("error: miss report id %0h at %0t was not expected", miss.id, $time);
        protocol_errs++;
      end else begin
        mexp = miss_exp_q.pop_front();
        check_miss(miss, mexp);
      end
      misses_seen++;
    end
  end

  function automatic logic page_match(input tlb_entry_t e, input addr_t a, output addr_t pa);
    int unsigned pg;
    int unsigned first;
    int unsigned last;
    int unsigned phys;
    pg    = a >> PB;
    first = 32'(e.first_page);
    last  = 32'(e.last_page);
    phys  = 32'(e.phys_page);
    pa    = (addr_t'(phys + pg - first) << PB) | (a & OFFS_MASK);
    return e.valid && (pg >= first) && (pg <= last);
  endfunction

  // returns 1 for an L1 hit, 2 for an L2 hit and 0 when both tables miss
  function automatic int ref_lookup(input addr_t a, output addr_t pa);
    for (int i = 0; i < L1N; i++) begin
      if (page_match(l1_model[i], a, pa)) return 1;
    end
    for (int i = 0; i < L2N; i++) begin
      if (page_match(l2_model[i], a, pa)) return 2;
    end
    return 0;
  endfunction

  // the top id bit separates L1 hits from slot beats, which may pass each other
  function automatic aw_chan_t rand_beat(input int unsigned page);
    logic [95:0] r;
    aw_chan_t    b;
    addr_t       pa;
    r      = {$urandom, $urandom, $urandom};
    b      = r[$bits(aw_chan_t)-1:0];
    b.addr = (addr_t'(page) << PB) | (addr_t'(r[95:64]) >> (32 - PB));
    b.id[`REMAP_ID_W-1] = (ref_lookup(b.addr, pa) != 1);
    return b;
  endfunction

  task automatic cfg_transfer(input logic we, input logic [8:0] adr, input logic [31:0] data);
    int n;
    cfg_cyc   = 1'b1;
    cfg_stb   = 1'b1;
    cfg_we    = we;
    cfg_adr   = adr;
    cfg_dat_w = data;
    n = 0;
    @(negedge axi4_aclk);
    while (!cfg_ack && n < TIMEOUT) begin
      n++;
      @(negedge axi4_aclk);
    end
    if (!cfg_ack) begin
      timeout_error("Wishbone ack");
    end else if (n != 1) begin
      $display("FAILED at %0t: Wishbone ack after %0d cycles, expected 1", $time, n);
      mismatches++;
    end else if (!we && cfg_dat_r !== 32'h0) begin
      $display("FAILED at %0t: Wishbone read data %h, expected 0", $time, cfg_dat_r);
      mismatches++;
    end
    @(posedge axi4_aclk);
    #1;
    cfg_cyc = 1'b0;
    cfg_stb = 1'b0;
    cfg_we  = 1'b0;
    @(negedge axi4_aclk);
    if (cfg_ack) begin
      $display("error: Wishbone ack stayed high for a second cycle at %0t", $time);
      protocol_errs++;
    end
    @(posedge axi4_aclk);
    #1;
  endtask

  task automatic wb_write(input logic sel_l2, input int idx, input int word, input logic [31:0] d);
    cfg_transfer(1'b1, {sel_l2, 4'(idx), 2'(word), 2'b00}, d);
  endtask

  task automatic write_entry(input logic sel_l2, input int idx, input page_t first,
                             input page_t last, input page_t phys, input logic valid);
    wb_write(sel_l2, idx, 0, 32'(first));
    wb_write(sel_l2, idx, 1, 32'(last));
    wb_write(sel_l2, idx, 2, 32'(phys));
    wb_write(sel_l2, idx, 3, {31'h0, valid});
    if (sel_l2) begin
      l2_model[idx] = '{valid: valid, first_page: first, last_page: last, phys_page: phys};
    end else if (idx < L1N) begin
      l1_model[idx] = '{valid: valid, first_page: first, last_page: last, phys_page: phys};
    end
  endtask

  task automatic aw_send(input aw_chan_t beat, output int waits);
    addr_t    pa;
    aw_chan_t e;
    if (ref_lookup(beat.addr, pa) == 0) begin
      miss_exp_q.push_back('{valid: 1'b1, id: beat.id, addr: beat.addr});
    end else begin
      e      = beat;
      e.addr = pa;
      exp_q.push_back(e);
    end
    s_aw_valid = 1'b1;
    s_aw       = beat;
    waits      = 0;
    @(negedge axi4_aclk);
    while (!s_aw_ready && waits < TIMEOUT) begin
      waits++;
      @(negedge axi4_aclk);
    end
    if (!s_aw_ready) timeout_error("s_aw_ready");
    @(posedge axi4_aclk);
    #1;
    s_aw_valid = 1'b0;
  endtask

  task automatic wait_drained();
    int n;
    n = 0;
    while ((exp_q.size() != 0 || miss_exp_q.size() != 0) && n < TIMEOUT) begin
      n++;
      @(negedge axi4_aclk);
    end
    if (exp_q.size() != 0 || miss_exp_q.size() != 0) begin
      timeout_error("master beat or miss report for every sent beat");
      exp_q.delete();
      miss_exp_q.delete();
    end
    @(posedge axi4_aclk);
    #1;
  endtask

  task automatic config_tables();
    write_entry(1'b0, 0, 20'h00100, 20'h0010f, 20'h80000, 1'b1);
    write_entry(1'b0, 1, 20'h00108, 20'h00117, 20'h90000, 1'b1);
    write_entry(1'b0, 2, 20'h00200, 20'h00203, 20'ha0010, 1'b1);
    write_entry(1'b0, 3, 20'h00300, 20'h003ff, 20'hb0000, 1'b0);
    // index 6 does not exist in L1 so its pages must stay unmapped
    write_entry(1'b0, 6, 20'h05000, 20'h050ff, 20'hf0000, 1'b1);
    write_entry(1'b1, 5, 20'h00300, 20'h0033f, 20'hc0000, 1'b1);
    write_entry(1'b1, 9, 20'h00320, 20'h0037f, 20'hd0000, 1'b1);
    write_entry(1'b1, 15, 20'h04000, 20'h04000, 20'he1234, 1'b1);
    cfg_transfer(1'b0, 9'h004, 32'h0);
    cfg_transfer(1'b0, 9'h1f0, 32'h0);
  endtask

  // an L1 hit reaches the master side in the cycle it is accepted
  task automatic l1_hit_forward();
    int waits;
    int seen;
    for (int i = 0; i < 6; i++) begin
      seen = beats_seen;
      aw_send(rand_beat((i % 2 == 0) ? 32'h100 + i : 32'h200 + (i % 4)), waits);
      if (waits != 0 || beats_seen != seen + 1) begin
        $display("FAILED at %0t: L1 hit stalled %0d cycles with %0d master beats, expected 0 and 1",
                 $time, waits, beats_seen - seen);
        mismatches++;
      end
    end
    wait_drained();
  endtask

  task automatic l2_hit_overtake();
    int waits_a;
    int waits_b;
    aw_send(rand_beat(32'h310), waits_a);
    aw_send(rand_beat(32'h201), waits_b);
    if (waits_a != 0 || waits_b != 0) begin
      $display("FAILED at %0t: L2 park waited %0d, L1 hit waited %0d, expected 0 and 0",
               $time, waits_a, waits_b);
      mismatches++;
    end
    wait_drained();
    aw_send(rand_beat(32'h4000), waits_a);
    wait_drained();
  endtask

  task automatic double_miss_stall();
    int waits;
    int seen;
    aw_send(rand_beat(32'h5000), waits);
    seen = misses_seen;
    aw_send(rand_beat(32'h5a00), waits);
    if (waits == 0 || misses_seen != seen + 1) begin
      $display("FAILED at %0t: second miss taken after %0d cycles with %0d misses reported",
               $time, waits, misses_seen - seen);
      mismatches++;
    end
    wait_drained();
  endtask

  task automatic random_backpressure();
    int          waits;
    int unsigned page;
    stall_en = 1'b1;
    // overlapping pages come first and the lowest index must win in both tables
    aw_send(rand_beat(32'h10a), waits);
    aw_send(rand_beat(32'h330), waits);
    for (int i = 0; i < 60; i++) begin
      case ($urandom % 5)
        0:       page = 32'h100 + ($urandom % 24);
        1:       page = 32'h200 + ($urandom % 4);
        2:       page = 32'h300 + ($urandom % 128);
        3:       page = 32'h4000;
        default: page = 32'h5000 + ($urandom % 256);
      endcase
      aw_send(rand_beat(page), waits);
    end
    wait_drained();
    stall_en = 1'b0;
  endtask

  initial begin : main
    int n;
    int errors;
    void'($urandom(32'h351b));
    cfg_cyc       = 1'b0;
    cfg_stb       = 1'b0;
    cfg_we        = 1'b0;
    cfg_adr       = '0;
    cfg_dat_w     = '0;
    s_aw_valid    = 1'b0;
    s_aw          = '0;
    stall_en      = 1'b0;
    mismatches    = 0;
    protocol_errs = 0;
    timeouts      = 0;
    beats_seen    = 0;
    misses_seen   = 0;
    for (int i = 0; i < 8; i++) begin
      stall_pat[i*32 +: 32] = $urandom;
    end
    for (int i = 0; i < L1N; i++) begin
      l1_model[i] = '0;
    end
    for (int i = 0; i < L2N; i++) begin
      l2_model[i] = '0;
    end
    n = 0;
    while (axi4_arstn !== 1'b1 && n < 20) begin
      n++;
      @(posedge axi4_aclk);
    end
    if (axi4_arstn !== 1'b1) timeout_error("reset release");
    @(negedge axi4_aclk);
    if (m_aw_valid || miss.valid || cfg_ack) begin
      $display("error: outputs not idle after reset at %0t", $time);
      protocol_errs++;
    end
    @(posedge axi4_aclk);
    #1;
    config_tables();
    l1_hit_forward();
    l2_hit_overtake();
    double_miss_stall();
    random_backpressure();
    errors = mismatches + protocol_errs + timeouts;
    $display("errors %0d: mismatches %0d, protocol %0d, timeouts %0d (beats %0d, misses %0d)",
             errors, mismatches, protocol_errs, timeouts, beats_seen, misses_seen);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

//--- sim/clk_rst_gen.sv
// testbench clock and reset source
// the clock runs free with a 20 ns period
// reset is held low for 2 rising edges and released 1 ns after the second

`timescale 1ns/1ps

module clk_rst_gen #(
  parameter int HALF_PERIOD_NS = 10,
  parameter int RST_CYCLES     = 2
) (
  output logic axi4_aclk_o,
  output logic axi4_arstn_o
);

  initial begin
    axi4_aclk_o = 1'b0;
    forever #(HALF_PERIOD_NS) axi4_aclk_o = ~axi4_aclk_o;
  end

  initial begin
    axi4_arstn_o = 1'b0;
    repeat (RST_CYCLES) @(posedge axi4_aclk_o);
    #1;
    axi4_arstn_o = 1'b1;
  end

endmodule

//--- design/aw_remap_top.sv
// AW address remapping unit with a 4-entry L1 and a 16-entry L2 table
// only the AW channel is handled, W and B must be routed outside
// tables are written over Wishbone and start out all invalid

`timescale 1ns/1ps

module aw_remap_top
  import axi_aw_pkg::*;
  import remap_pkg::*;
(
  input  logic        axi4_aclk,
  input  logic        axi4_arstn,
  input  logic        cfg_cyc_i,
  input  logic        cfg_stb_i,
  input  logic        cfg_we_i,
  input  logic [8:0]  cfg_adr_i,
  input  logic [31:0] cfg_dat_i,
  output logic        cfg_ack_o,
  output logic [31:0] cfg_dat_o,
  input  logic        s_aw_valid_i,
  input  aw_chan_t    s_aw_i,
  output logic        s_aw_ready_o,
  output logic        m_aw_valid_o,
  output aw_chan_t    m_aw_o,
  input  logic        m_aw_ready_i,
  output miss_t       miss_o
);

  tbl_write_t tbl_wr;
  xlate_t     l1_xlate;
  xlate_t     l2_xlate;
  logic       l2_req;
  logic       l2_busy;
  logic       l2_result_valid;

  remap_cfg_wb cfg_wb_i (
    .axi4_aclk  (axi4_aclk),
    .axi4_arstn (axi4_arstn),
    .cfg_cyc_i  (cfg_cyc_i),
    .cfg_stb_i  (cfg_stb_i),
    .cfg_we_i   (cfg_we_i),
    .cfg_adr_i  (cfg_adr_i),
    .cfg_dat_i  (cfg_dat_i),
    .cfg_ack_o  (cfg_ack_o),
    .cfg_dat_o  (cfg_dat_o),
    .tbl_wr_o   (tbl_wr)
  );

  l1_tlb l1_tlb_i (
    .axi4_aclk  (axi4_aclk),
    .axi4_arstn (axi4_arstn),
    .tbl_wr_i   (tbl_wr),
    .addr_i     (s_aw_i.addr),
    .xlate_o    (l1_xlate)
  );

  // L2 latches the slave address in the cycle the sender parks the beat
  l2_tlb l2_tlb_i (
    .axi4_aclk      (axi4_aclk),
    .axi4_arstn     (axi4_arstn),
    .tbl_wr_i       (tbl_wr),
    .req_i          (l2_req),
    .addr_i         (s_aw_i.addr),
    .busy_o         (l2_busy),
    .result_valid_o (l2_result_valid),
    .xlate_o        (l2_xlate)
  );

  aw_sender aw_sender_i (
    .axi4_aclk         (axi4_aclk),
    .axi4_arstn        (axi4_arstn),
    .s_aw_valid_i      (s_aw_valid_i),
    .s_aw_i            (s_aw_i),
    .s_aw_ready_o      (s_aw_ready_o),
    .l1_xlate_i        (l1_xlate),
    .l2_req_o          (l2_req),
    .l2_busy_i         (l2_busy),
    .l2_result_valid_i (l2_result_valid),
    .l2_xlate_i        (l2_xlate),
    .m_aw_valid_o      (m_aw_valid_o),
    .m_aw_o            (m_aw_o),
    .m_aw_ready_i      (m_aw_ready_i),
    .miss_o            (miss_o)
  );

endmodule

//--- design/aw_sender.sv
// merges L1 and L2 results onto the master AW channel
// a single parking slot holds one L1 miss while L2 searches
// an L1 hit may overtake a parked beat, so order between ids is not kept
// a beat that misses both tables is dropped and shows up on miss_o only

`timescale 1ns/1ps
`include "remap_config.svh"

module aw_sender
  import axi_aw_pkg::*;
  import remap_pkg::*;
(
  input  logic     axi4_aclk,
  input  logic     axi4_arstn,
  input  logic     s_aw_valid_i,
  input  aw_chan_t s_aw_i,
  output logic     s_aw_ready_o,
  input  xlate_t   l1_xlate_i,
  output logic     l2_req_o,
  input  logic     l2_busy_i,
  input  logic     l2_result_valid_i,
  input  xlate_t   l2_xlate_i,
  output logic     m_aw_valid_o,
  output aw_chan_t m_aw_o,
  input  logic     m_aw_ready_i,
  output miss_t    miss_o
);

  typedef enum logic [1:0] {
    st_free,
    st_wait,
    st_send
  } slot_state_e;

  slot_state_e state_q;
  aw_chan_t    slot_q;
  aw_chan_t    l1_beat;
  logic        slot_free;
  logic        save;
  logic        l2_sending;
  logic        l1_owns_q;

  // an L1 beat stalled on the master port keeps the port until it is taken
  assign l2_sending = (state_q == st_send) & ~l1_owns_q;
  assign slot_free  = (state_q == st_free) & ~l2_busy_i;
  assign save       = s_aw_valid_i & ~l1_xlate_i.hit & slot_free;

  always_comb begin
    l1_beat      = s_aw_i;
    l1_beat.addr = l1_xlate_i.addr;
  end

  assign m_aw_valid_o = l2_sending | (s_aw_valid_i & l1_xlate_i.hit);
  assign m_aw_o       = l2_sending ? slot_q : l1_beat;
  assign s_aw_ready_o = l1_xlate_i.hit ? (m_aw_ready_i & ~l2_sending) : slot_free;
  assign l2_req_o     = save;

  always_ff @(posedge axi4_aclk or negedge axi4_arstn) begin
    if (!axi4_arstn) begin
      l1_owns_q <= 1'b0;
    end else begin
      l1_owns_q <= m_aw_valid_o & ~m_aw_ready_i & ~l2_sending;
    end
  end

  always_ff @(posedge axi4_aclk or negedge axi4_arstn) begin
    if (!axi4_arstn) begin
      state_q <= st_free;
    end else begin
      case (state_q)
        st_free: if (save) state_q <= st_wait;
        st_wait: begin
          if (l2_result_valid_i) begin
            state_q <= l2_xlate_i.hit ? st_send : st_free;
          end
        end
        st_send: if (l2_sending && m_aw_ready_i) state_q <= st_free;
        default: state_q <= st_free;
      endcase
    end
  end

  // the parked beat keeps its virtual address until L2 answers with a hit
  always_ff @(posedge axi4_aclk) begin
    if (save) begin
      slot_q <= s_aw_i;
    end else if ((state_q == st_wait) && l2_result_valid_i && l2_xlate_i.hit) begin
      slot_q.addr <= l2_xlate_i.addr;
    end
  end

  assign miss_o.valid = (state_q == st_wait) & l2_result_valid_i & ~l2_xlate_i.hit;
  assign miss_o.id    = slot_q.id;
  assign miss_o.addr  = slot_q.addr;

  m_aw_stable: assert property (@(posedge axi4_aclk) disable iff (!axi4_arstn)
    m_aw_valid_o && !m_aw_ready_i |=> m_aw_valid_o && $stable(m_aw_o));

endmodule

//--- design/l2_tlb.sv
// second-level table, searched one entry per clock from index 0
// only one request may be in flight, req_i while busy is not allowed
// result_valid_o comes 1 to L2_ENTRIES cycles after req_i

`timescale 1ns/1ps
`include "remap_config.svh"

module l2_tlb
  import axi_aw_pkg::*;
  import remap_pkg::*;
(
  input  logic       axi4_aclk,
  input  logic       axi4_arstn,
  input  tbl_write_t tbl_wr_i,
  input  logic       req_i,
  input  addr_t      addr_i,
  output logic       busy_o,
  output logic       result_valid_o,
  output xlate_t     xlate_o
);

  localparam int unsigned N     = `REMAP_L2_ENTRIES;
  localparam int unsigned IDX_W = $clog2(N);

  logic       valid_q [N];
  page_t      first_q [N];
  page_t      last_q  [N];
  page_t      phys_q  [N];
  logic       busy_q;
  logic [IDX_W-1:0] ptr_q;
  addr_t      addr_q;
  tlb_entry_t cur_entry;
  logic       cur_hit;
  logic       last_entry;
  logic       wr_en;

  assign wr_en = tbl_wr_i.we && tbl_wr_i.sel_l2;

  always_ff @(posedge axi4_aclk or negedge axi4_arstn) begin
    if (!axi4_arstn) begin
      for (int i = 0; i < N; i++) begin
        valid_q[i] <= 1'b0;
      end
    end else if (wr_en && (tbl_wr_i.word == 2'd3)) begin
      valid_q[tbl_wr_i.idx] <= tbl_wr_i.data[0];
    end
  end

  always_ff @(posedge axi4_aclk) begin
    if (wr_en) begin
      case (tbl_wr_i.word)
        2'd0:    first_q[tbl_wr_i.idx] <= tbl_wr_i.data[$bits(page_t)-1:0];
        2'd1:    last_q[tbl_wr_i.idx]  <= tbl_wr_i.data[$bits(page_t)-1:0];
        2'd2:    phys_q[tbl_wr_i.idx]  <= tbl_wr_i.data[$bits(page_t)-1:0];
        default: ;
      endcase
    end
  end

  assign cur_entry  = '{valid: valid_q[ptr_q], first_page: first_q[ptr_q],
                        last_page: last_q[ptr_q], phys_page: phys_q[ptr_q]};
  assign cur_hit    = entry_hit(cur_entry, addr_q);
  assign last_entry = (ptr_q == IDX_W'(N - 1));

  // the walk ends on the first hit or after the last entry has been checked
  always_ff @(posedge axi4_aclk or negedge axi4_arstn) begin
    if (!axi4_arstn) begin
      busy_q <= 1'b0;
      ptr_q  <= '0;
    end else if (req_i) begin
      busy_q <= 1'b1;
      ptr_q  <= '0;
    end else if (busy_q) begin
      if (cur_hit || last_entry) begin
        busy_q <= 1'b0;
      end else begin
        ptr_q <= ptr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge axi4_aclk) begin
    if (req_i) begin
      addr_q <= addr_i;
    end
  end

  assign busy_o         = busy_q;
  assign result_valid_o = busy_q & (cur_hit | last_entry);
  assign xlate_o.hit    = busy_q & cur_hit;
  assign xlate_o.addr   = entry_xlate(cur_entry, addr_q);

  no_req_while_busy: assert property (@(posedge axi4_aclk) disable iff (!axi4_arstn)
    req_i |-> !busy_o);

endmodule

//--- design/l1_tlb.sv
// first-level table, fully associative, answers in the same cycle
// writes with an entry index beyond the table size are ignored
// on overlapping entries the lowest index wins

`timescale 1ns/1ps
`include "remap_config.svh"

module l1_tlb
  import axi_aw_pkg::*;
  import remap_pkg::*;
(
  input  logic       axi4_aclk,
  input  logic       axi4_arstn,
  input  tbl_write_t tbl_wr_i,
  input  addr_t      addr_i,
  output xlate_t     xlate_o
);

  localparam int unsigned N     = `REMAP_L1_ENTRIES;
  localparam int unsigned IDX_W = $clog2(N);

  logic       valid_q [N];
  page_t      first_q [N];
  page_t      last_q  [N];
  page_t      phys_q  [N];
  tlb_entry_t entry   [N];
  logic       wr_en;
  logic [IDX_W-1:0] wr_idx;

  assign wr_en  = tbl_wr_i.we && !tbl_wr_i.sel_l2 && (tbl_wr_i.idx < N);
  assign wr_idx = tbl_wr_i.idx[IDX_W-1:0];

  // flags word, bit 0 is the only one used
  always_ff @(posedge axi4_aclk or negedge axi4_arstn) begin
    if (!axi4_arstn) begin
      for (int i = 0; i < N; i++) begin
        valid_q[i] <= 1'b0;
      end
    end else if (wr_en && (tbl_wr_i.word == 2'd3)) begin
      valid_q[wr_idx] <= tbl_wr_i.data[0];
    end
  end

  always_ff @(posedge axi4_aclk) begin
    if (wr_en) begin
      case (tbl_wr_i.word)
        2'd0:    first_q[wr_idx] <= tbl_wr_i.data[$bits(page_t)-1:0];
        2'd1:    last_q[wr_idx]  <= tbl_wr_i.data[$bits(page_t)-1:0];
        2'd2:    phys_q[wr_idx]  <= tbl_wr_i.data[$bits(page_t)-1:0];
        default: ;
      endcase
    end
  end

  always_comb begin
    for (int i = 0; i < N; i++) begin
      entry[i] = '{valid: valid_q[i], first_page: first_q[i],
                   last_page: last_q[i], phys_page: phys_q[i]};
    end
  end

  // scan from the top so that the lowest hitting index is the last to assign
  always_comb begin
    xlate_o = '0;
    for (int i = N - 1; i >= 0; i--) begin
      if (entry_hit(entry[i], addr_i)) begin
        xlate_o.hit  = 1'b1;
        xlate_o.addr = entry_xlate(entry[i], addr_i);
      end
    end
  end

endmodule

//--- design/remap_cfg_wb.sv
// Wishbone classic slave for the translation tables that handles single transfers only
// reads are acknowledged with zero data and there is no table readback
// the master must hold cyc and stb until ack

`timescale 1ns/1ps
`include "remap_config.svh"

module remap_cfg_wb
  import remap_pkg::*;
(
  input  logic        axi4_aclk,
  input  logic        axi4_arstn,
  input  logic        cfg_cyc_i,
  input  logic        cfg_stb_i,
  input  logic        cfg_we_i,
  input  logic [8:0]  cfg_adr_i,
  input  logic [31:0] cfg_dat_i,
  output logic        cfg_ack_o,
  output logic [31:0] cfg_dat_o,
  output tbl_write_t  tbl_wr_o
);

  logic                                 strobe;
  logic                                 ack_q;
  logic                                 wr_we_q;
  logic                                 sel_l2_q;
  logic [$clog2(`REMAP_L2_ENTRIES)-1:0] idx_q;
  logic [1:0]                           word_q;
  logic [31:0]                          data_q;

  // a new transfer starts only when no ack is pending, so ack lasts one cycle
  assign strobe = cfg_cyc_i & cfg_stb_i & ~ack_q;

  always_ff @(posedge axi4_aclk or negedge axi4_arstn) begin
    if (!axi4_arstn) begin
      ack_q   <= 1'b0;
      wr_we_q <= 1'b0;
    end else begin
      ack_q   <= strobe;
      wr_we_q <= strobe & cfg_we_i;
    end
  end

  // the decoded write fields are only meaningful while wr_we_q is high
  always_ff @(posedge axi4_aclk) begin
    if (strobe) begin
      sel_l2_q <= cfg_adr_i[8];
      idx_q    <= cfg_adr_i[7:4];
      word_q   <= cfg_adr_i[3:2];
      data_q   <= cfg_dat_i;
    end
  end

  assign cfg_ack_o = ack_q;
  assign cfg_dat_o = 32'h0;
  assign tbl_wr_o  = '{we: wr_we_q, sel_l2: sel_l2_q, idx: idx_q, word: word_q, data: data_q};

  // the master keeps cyc and stb up until the ack arrives
  stb_held_until_ack: assert property (@(posedge axi4_aclk) disable iff (!axi4_arstn)
    cfg_cyc_i && cfg_stb_i && !cfg_ack_o |=> cfg_cyc_i && cfg_stb_i);

endmodule

//--- design/remap_pkg.sv
// translation table types and the shared translation rule
// an entry covers the pages first_page..last_page, both ends included

package remap_pkg;

  `include "remap_config.svh"
  import axi_aw_pkg::*;

  typedef logic [`REMAP_ADDR_W-`REMAP_PAGE_BITS-1:0] page_t;

  typedef struct packed {
    logic  valid;
    page_t first_page;
    page_t last_page;
    page_t phys_page;
  } tlb_entry_t;

  // word 0 first page, 1 last page, 2 physical page, 3 flags (bit 0 valid)
  typedef struct packed {
    logic                                 we;
    logic                                 sel_l2;
    logic [$clog2(`REMAP_L2_ENTRIES)-1:0] idx;
    logic [1:0]                           word;
    logic [31:0]                          data;
  } tbl_write_t;

  typedef struct packed {
    logic  hit;
    addr_t addr;
  } xlate_t;

  typedef struct packed {
    logic  valid;
    id_t   id;
    addr_t addr;
  } miss_t;

  function automatic logic entry_hit(tlb_entry_t e, addr_t a);
    page_t pg;
    pg = a[`REMAP_ADDR_W-1:`REMAP_PAGE_BITS];
    return e.valid && (pg >= e.first_page) && (pg <= e.last_page);
  endfunction

  // the page offset passes through untouched
  function automatic addr_t entry_xlate(tlb_entry_t e, addr_t a);
    page_t pg;
    page_t phys;
    pg   = a[`REMAP_ADDR_W-1:`REMAP_PAGE_BITS];
    phys = e.phys_page + (pg - e.first_page);
    return {phys, a[`REMAP_PAGE_BITS-1:0]};
  endfunction

endpackage

//--- design/axi_aw_pkg.sv
// AXI4 write-address channel field types
// valid and ready are kept out of aw_chan_t and travel as separate wires

package axi_aw_pkg;

  `include "remap_config.svh"

  typedef logic [7:0]                 len_t;
  typedef logic [2:0]                 size_t;
  typedef logic [1:0]                 burst_t;
  typedef logic [3:0]                 cache_t;
  typedef logic [2:0]                 prot_t;
  typedef logic [3:0]                 qos_t;
  typedef logic [3:0]                 region_t;
  typedef logic [`REMAP_ID_W-1:0]     id_t;
  typedef logic [`REMAP_USER_W-1:0]   user_t;
  typedef logic [`REMAP_ADDR_W-1:0]   addr_t;

  typedef struct packed {
    id_t     id;
    addr_t   addr;
    len_t    len;
    size_t   size;
    burst_t  burst;
    logic    lock;
    cache_t  cache;
    prot_t   prot;
    qos_t    qos;
    region_t region;
    user_t   user;
  } aw_chan_t;

endpackage

//--- design/remap_config.svh
// build-wide sizes for the AW remapping unit
// the Wishbone data path is fixed at 32 bits, so page numbers must fit in 32 bits
// L1_ENTRIES must not exceed L2_ENTRIES, both powers of two

`ifndef REMAP_CONFIG_SVH
`define REMAP_CONFIG_SVH

`define REMAP_ADDR_W      32
`define REMAP_ID_W        4
`define REMAP_USER_W      2

// 4 KiB pages
`define REMAP_PAGE_BITS   12

`define REMAP_L1_ENTRIES  4
`define REMAP_L2_ENTRIES  16

`endif
